// File: Makefile
VERILATOR := verilator
TOP := tb_cpu_bus_fabric
FILELIST := files.f
OBJ_DIR := obj_dir
VFLAGS := --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir $(OBJ_DIR)
PASS_TEXT := All tests passed!

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/cpu_bus_pkg.sv
logic/mem_arbiter.sv
logic/line_cache.sv
logic/cpu_bus_fabric.sv
testbench/cpu_bus_fabric_asserts.sv
testbench/tb_cpu_bus_fabric.sv

// File: logic/cpu_bus_fabric.sv
`timescale 1ns/1ps

module cpu_bus_fabric (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cache_enabled,
  input  cpu_bus_pkg::bus_req_t instr_req,
  output cpu_bus_pkg::bus_rsp_t instr_rsp,
  input  cpu_bus_pkg::bus_req_t data_req,
  output cpu_bus_pkg::bus_rsp_t data_rsp,
  output cpu_bus_pkg::io_req_t  io_req,
  input  cpu_bus_pkg::bus_rsp_t io_rsp,
  output cpu_bus_pkg::bus_req_t mem_req,
  input  cpu_bus_pkg::bus_rsp_t mem_rsp
);

  cpu_bus_pkg::bus_req_t fetch_req;
  cpu_bus_pkg::bus_req_t mem_data_req;
  cpu_bus_pkg::bus_rsp_t arb_data_rsp;
  cpu_bus_pkg::bus_req_t arb_req;
  cpu_bus_pkg::bus_rsp_t cache_rsp;

  // Fetch port only reads whole words
  assign fetch_req = '{access: instr_req.access, wr_en: 1'b0, io: 1'b0,
                       addr: instr_req.addr, data: '0, bytesel: 2'b11};

  // I/O requests leave the data port here
  assign io_req = '{access: data_req.access & data_req.io, wr_en: data_req.wr_en,
                    addr: data_req.addr[15:1], data: data_req.data,
                    bytesel: data_req.bytesel};

  // Remaining data traffic competes for memory
  assign mem_data_req = '{access: data_req.access & ~data_req.io, wr_en: data_req.wr_en,
                          io: 1'b0, addr: data_req.addr, data: data_req.data,
                          bytesel: data_req.bytesel};

  // Only one of the two paths can ack a given data request
  assign data_rsp = '{ack: io_rsp.ack | arb_data_rsp.ack,
                      data: data_req.io ? io_rsp.data : arb_data_rsp.data};

  mem_arbiter i_mem_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr_req (fetch_req),
    .data_req  (mem_data_req),
    .down_rsp  (cache_rsp),
    .instr_rsp (instr_rsp),
    .data_rsp  (arb_data_rsp),
    .down_req  (arb_req)
  );

  line_cache i_line_cache (
    .clk     (clk),
    .arst_n  (arst_n),
    .enabled (cache_enabled),
    .up_req  (arb_req),
    .mem_rsp (mem_rsp),
    .up_rsp  (cache_rsp),
    .mem_req (mem_req)
  );

endmodule

// File: logic/cpu_bus_pkg.sv
package cpu_bus_pkg;

  // Cache geometry
  localparam int cache_lines = 64;
  localparam int line_words = 8;
  localparam int index_bits = $clog2(cache_lines);
  localparam int offset_bits = $clog2(line_words);
  // Word address is bits 19 to 1, the rest is tag
  localparam int tag_bits = 19 - index_bits - offset_bits;

  // One request on a 16-bit memory bus
  typedef struct packed {
    logic        access;
    logic        wr_en;
    logic        io;
    logic [19:1] addr;
    logic [15:0] data;
    logic [1:0]  bytesel;
  } bus_req_t;

  // Ack is a single-cycle pulse, read data valid with it
  typedef struct packed {
    logic        ack;
    logic [15:0] data;
  } bus_rsp_t;

  // I/O bus request, 64K byte port space
  typedef struct packed {
    logic        access;
    logic        wr_en;
    logic [15:1] addr;
    logic [15:0] data;
    logic [1:0]  bytesel;
  } io_req_t;

endpackage

// File: logic/line_cache.sv
`timescale 1ns/1ps

module line_cache (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  enabled,
  input  cpu_bus_pkg::bus_req_t up_req,
  input  cpu_bus_pkg::bus_rsp_t mem_rsp,
  output cpu_bus_pkg::bus_rsp_t up_rsp,
  output cpu_bus_pkg::bus_req_t mem_req
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fill,
    st_write,
    st_bypass
  } state_t;

  state_t state;

  // Address split of the held upstream request
  logic [cpu_bus_pkg::tag_bits-1:0]    req_tag;
  logic [cpu_bus_pkg::index_bits-1:0]  req_index;
  logic [cpu_bus_pkg::offset_bits-1:0] req_offset;

  // Line storage
  logic [cpu_bus_pkg::cache_lines-1:0] line_valid;
  logic [cpu_bus_pkg::tag_bits-1:0]    line_tag [cpu_bus_pkg::cache_lines];
  logic [15:0] line_data [cpu_bus_pkg::cache_lines * cpu_bus_pkg::line_words];

  // Lookup results, registered out of the arrays
  logic                             rd_valid;
  logic [cpu_bus_pkg::tag_bits-1:0] rd_tag;
  logic [15:0]                      rd_word;
  logic                             lookup_hit;

  // Line fill sequencing
  logic [cpu_bus_pkg::offset_bits-1:0] fill_cnt;
  logic                                fill_last;
  logic [15:0]                         fill_word;

  logic [15:0] merged_word;
  logic        rsp_ack;
  logic [15:0] rsp_data;

  assign {req_tag, req_index, req_offset} = up_req.addr;

  assign lookup_hit = rd_valid && (rd_tag == req_tag);
  assign fill_last = &fill_cnt;

  // Write data merged over the stored word by byte lane
  assign merged_word = {
    up_req.bytesel[1] ? up_req.data[15:8] : rd_word[15:8],
    up_req.bytesel[0] ? up_req.data[7:0] : rd_word[7:0]
  };

  assign up_rsp = '{ack: rsp_ack, data: rsp_data};

  // Control FSM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      fill_cnt <= '0;
      rsp_ack <= 1'b0;
      line_valid <= '0;
    end else begin
      rsp_ack <= 1'b0;
      case (state)
        st_idle: begin
          // Access is still held during our own ack cycle
          if (up_req.access && !rsp_ack) begin
            state <= st_lookup;
          end
        end
        st_lookup: begin
          if (!enabled) begin
            state <= st_bypass;
          end else if (up_req.wr_en) begin
            state <= st_write;
          end else if (lookup_hit) begin
            rsp_ack <= 1'b1;
            state <= st_idle;
          end else begin
            fill_cnt <= '0;
            state <= st_fill;
          end
        end
        st_fill: begin
          if (mem_rsp.ack) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_last) begin
              line_valid[req_index] <= 1'b1;
              rsp_ack <= 1'b1;
              state <= st_idle;
            end
          end
        end
        st_write, st_bypass: begin
          // One memory access, ack passed on a cycle later
          if (mem_rsp.ack) begin
            rsp_ack <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Array access and response data
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      rd_valid <= line_valid[req_index];
      rd_tag <= line_tag[req_index];
      rd_word <= line_data[{req_index, req_offset}];
    end

    if (state == st_lookup && lookup_hit) begin
      rsp_data <= rd_word;
    end

    if (state == st_fill && mem_rsp.ack) begin
      line_data[{req_index, fill_cnt}] <= mem_rsp.data;
      if (fill_cnt == req_offset) begin
        fill_word <= mem_rsp.data;
      end
      if (fill_last) begin
        line_tag[req_index] <= req_tag;
        // Requested word may be the one arriving now
        rsp_data <= (fill_cnt == req_offset) ? mem_rsp.data : fill_word;
      end
    end

    if ((state == st_write || state == st_bypass) && mem_rsp.ack) begin
      rsp_data <= mem_rsp.data;
      // Keeps a valid line coherent, also while disabled
      if (up_req.wr_en && lookup_hit) begin
        line_data[{req_index, req_offset}] <= merged_word;
      end
    end
  end

  // Memory side request
  always_comb begin
    mem_req = '0;
    case (state)
      st_fill: begin
        mem_req.access = 1'b1;
        mem_req.wr_en = 1'b0;
        mem_req.addr = {req_tag, req_index, fill_cnt};
        mem_req.bytesel = 2'b11;
      end
      st_write, st_bypass: begin
        mem_req.access = 1'b1;
        mem_req.wr_en = up_req.wr_en;
        mem_req.addr = up_req.addr;
        mem_req.data = up_req.data;
        mem_req.bytesel = up_req.bytesel;
      end
      default: mem_req = '0;
    endcase
  end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                  clk,
  input  logic                  arst_n,
  input  cpu_bus_pkg::bus_req_t instr_req,
  input  cpu_bus_pkg::bus_req_t data_req,
  input  cpu_bus_pkg::bus_rsp_t down_rsp,
  output cpu_bus_pkg::bus_rsp_t instr_rsp,
  output cpu_bus_pkg::bus_rsp_t data_rsp,
  output cpu_bus_pkg::bus_req_t down_req
);

  typedef enum logic [1:0] {
    grant_idle,
    grant_instr,
    grant_data
  } grant_t;

  grant_t grant;

  // Grant taken only from idle, held until the downstream ack
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      grant <= grant_idle;
    end else begin
      case (grant)
        grant_idle: begin
          // Data side has priority over fetch
          if (data_req.access) begin
            grant <= grant_data;
          end else if (instr_req.access) begin
            grant <= grant_instr;
          end
        end
        default: begin
          if (down_rsp.ack) begin
            grant <= grant_idle;
          end
        end
      endcase
    end
  end

  // Granted request goes downstream, nothing while idle
  always_comb begin
    down_req = '0;
    case (grant)
      grant_instr: down_req = instr_req;
      grant_data:  down_req = data_req;
      default:     down_req = '0;
    endcase
  end

  // Response steered back only to the owner of the grant
  always_comb begin
    instr_rsp = '0;
    data_rsp = '0;
    if (grant == grant_instr) begin
      instr_rsp = down_rsp;
    end
    if (grant == grant_data) begin
      data_rsp = down_rsp;
    end
  end

endmodule

// File: testbench/cpu_bus_fabric_asserts.sv
`timescale 1ns/1ps

module cpu_bus_fabric_asserts (
  input logic                  clk,
  input logic                  arst_n,
  input cpu_bus_pkg::bus_req_t instr_req,
  input cpu_bus_pkg::bus_rsp_t instr_rsp,
  input cpu_bus_pkg::bus_req_t data_req,
  input cpu_bus_pkg::bus_rsp_t data_rsp,
  input cpu_bus_pkg::io_req_t  io_req,
  input cpu_bus_pkg::bus_rsp_t io_rsp,
  input cpu_bus_pkg::bus_req_t mem_req,
  input cpu_bus_pkg::bus_rsp_t mem_rsp
);

  // Acks are single-cycle pulses
  instr_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    instr_rsp.ack |=> !instr_rsp.ack) else $error("instruction ack high for two cycles");
  data_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    data_rsp.ack |=> !data_rsp.ack) else $error("data ack high for two cycles");
  mem_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp.ack |=> !mem_rsp.ack) else $error("memory ack high for two cycles");

  // Request held unchanged until its ack
  instr_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (instr_req.access && !instr_rsp.ack) |=> (instr_req == $past(instr_req)))
    else $error("instruction request changed before ack");
  data_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (data_req.access && !data_rsp.ack) |=> (data_req == $past(data_req)))
    else $error("data request changed before ack");
  io_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (io_req.access && !io_rsp.ack) |=> (io_req == $past(io_req)))
    else $error("I/O request changed before ack");
  mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (mem_req.access && !mem_rsp.ack) |=> (mem_req == $past(mem_req)))
    else $error("memory request changed before ack");

  // Fetch port is read-only
  instr_no_write: assert property (@(posedge clk) disable iff (!arst_n)
    instr_req.access |-> !instr_req.wr_en) else $error("instruction port issued a write");

  mem_quiet_in_reset: assert property (@(posedge clk)
    !arst_n |-> !mem_req.access) else $error("memory access during reset");

endmodule

bind cpu_bus_fabric cpu_bus_fabric_asserts i_cpu_bus_fabric_asserts (
  .clk       (clk),
  .arst_n    (arst_n),
  .instr_req (instr_req),
  .instr_rsp (instr_rsp),
  .data_req  (data_req),
  .data_rsp  (data_rsp),
  .io_req    (io_req),
  .io_rsp    (io_rsp),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp)
);

// File: testbench/tb_cpu_bus_fabric.sv
`timescale 1ns/1ps

module tb_cpu_bus_fabric;

  localparam int num_ops = 21;

  typedef struct packed {
    logic        is_data;
    logic        io;
    logic        wr_en;
    logic [18:0] addr;
    logic [1:0]  bytesel;
    logic [15:0] data;
    logic        cache_en;
    logic [15:0] exp_data;
    logic [7:0]  exp_mem;
    logic        with_next;
  } op_t;

  logic clk = 1'b0;
  logic arst_n;
  logic cache_enabled;
  cpu_bus_pkg::bus_req_t instr_req;
  cpu_bus_pkg::bus_rsp_t instr_rsp;
  cpu_bus_pkg::bus_req_t data_req;
  cpu_bus_pkg::bus_rsp_t data_rsp;
  cpu_bus_pkg::io_req_t  io_req;
  cpu_bus_pkg::bus_rsp_t io_rsp = '0;
  cpu_bus_pkg::bus_req_t mem_req;
  cpu_bus_pkg::bus_rsp_t mem_rsp = '0;

  op_t op_table [num_ops];

  // Memory model state, unwritten words follow word_pattern
  logic [15:0] mem_store [logic [18:0]];
  logic        mem_busy;
  logic [1:0]  mem_wait;
  int unsigned mem_count;

  // I/O model state
  logic [15:0] io_regs [16];
  logic [3:0]  io_last_addr;
  logic [15:0] io_last_data;

  always #2 clk = ~clk;

  cpu_bus_fabric i_cpu_bus_fabric (
    .clk           (clk),
    .arst_n        (arst_n),
    .cache_enabled (cache_enabled),
    .instr_req     (instr_req),
    .instr_rsp     (instr_rsp),
    .data_req      (data_req),
    .data_rsp      (data_rsp),
    .io_req        (io_req),
    .io_rsp        (io_rsp),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp)
  );

  function automatic logic [15:0] word_pattern(input logic [18:0] a);
    return a[15:0] ^ {a[18:16], 13'h0} ^ 16'hc35a;
  endfunction

  function automatic logic [15:0] merge_bytes(input logic [15:0] old_word,
                                              input logic [15:0] new_word,
                                              input logic [1:0] bytesel);
    return {bytesel[1] ? new_word[15:8] : old_word[15:8],
            bytesel[0] ? new_word[7:0] : old_word[7:0]};
  endfunction

  function automatic logic [15:0] mem_word(input logic [18:0] a);
    if (mem_store.exists(a)) begin
      return mem_store[a];
    end
    return word_pattern(a);
  endfunction

  // Memory answers each access 1 to 3 cycles after it is seen
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_rsp <= '0;
      mem_busy <= 1'b0;
      mem_wait <= '0;
      mem_count <= 0;
    end else begin
      mem_rsp.ack <= 1'b0;
      if (mem_busy) begin
        if (mem_wait == 2'd0) begin
          mem_busy <= 1'b0;
          mem_rsp.ack <= 1'b1;
          mem_rsp.data <= mem_word(mem_req.addr);
          mem_count <= mem_count + 1;
          if (mem_req.wr_en) begin
            mem_store[mem_req.addr] = merge_bytes(mem_word(mem_req.addr), mem_req.data,
                                                  mem_req.bytesel);
          end
        end else begin
          mem_wait <= mem_wait - 2'd1;
        end
      end else if (mem_req.access && !mem_rsp.ack) begin
        mem_busy <= 1'b1;
        mem_wait <= 2'($urandom % 3);
      end
    end
  end

  // I/O registers, ack one cycle after access
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      io_rsp <= '0;
      io_last_addr <= '0;
      io_last_data <= '0;
      for (int i = 0; i < 16; i++) begin
        io_regs[i] <= '0;
      end
    end else begin
      io_rsp.ack <= 1'b0;
      if (io_req.access && !io_rsp.ack) begin
        io_rsp.ack <= 1'b1;
        io_rsp.data <= io_regs[io_req.addr[4:1]];
        if (io_req.wr_en) begin
          io_regs[io_req.addr[4:1]] <= merge_bytes(io_regs[io_req.addr[4:1]], io_req.data,
                                                   io_req.bytesel);
          io_last_addr <= io_req.addr[4:1];
          io_last_data <= io_req.data;
        end
      end
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual,
               expected);
      $display("Test failures found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Columns: data port, io, wr_en, word addr, bytesel, write data, cache on,
  // expected read, expected memory accesses, issued together with the next entry
  task automatic load_table();
    // Fetch miss fills the line, then hits
    op_table[0]  = '{1'b0, 1'b0, 1'b0, 19'h00105, 2'b11, 16'h0000, 1'b1, 16'hc25f, 8'd8, 1'b0};
    op_table[1]  = '{1'b0, 1'b0, 1'b0, 19'h00107, 2'b11, 16'h0000, 1'b1, 16'hc25d, 8'd0, 1'b0};
    // Byte writes through to memory on a cached word
    op_table[2]  = '{1'b1, 1'b0, 1'b1, 19'h00102, 2'b01, 16'h11aa, 1'b1, 16'h0000, 8'd1, 1'b0};
    op_table[3]  = '{1'b1, 1'b0, 1'b1, 19'h00102, 2'b10, 16'h77bb, 1'b1, 16'h0000, 8'd1, 1'b0};
    op_table[4]  = '{1'b1, 1'b0, 1'b0, 19'h00102, 2'b11, 16'h0000, 1'b1, 16'h77aa, 8'd0, 1'b0};
    op_table[5]  = '{1'b0, 1'b0, 1'b0, 19'h00102, 2'b11, 16'h0000, 1'b1, 16'h77aa, 8'd0, 1'b0};
    op_table[6]  = '{1'b1, 1'b0, 1'b0, 19'h00102, 2'b11, 16'h0000, 1'b0, 16'h77aa, 8'd1, 1'b0};
    // I/O register 5, address overlaps a cached line
    op_table[7]  = '{1'b1, 1'b1, 1'b1, 19'h00105, 2'b11, 16'h5a5a, 1'b1, 16'h0000, 8'd0, 1'b0};
    op_table[8]  = '{1'b1, 1'b1, 1'b0, 19'h00105, 2'b11, 16'h0000, 1'b1, 16'h5a5a, 8'd0, 1'b0};
    // Cache off, every access goes to memory
    op_table[9]  = '{1'b1, 1'b0, 1'b0, 19'h00104, 2'b11, 16'h0000, 1'b0, 16'hc25e, 8'd1, 1'b0};
    op_table[10] = '{1'b1, 1'b0, 1'b1, 19'h00103, 2'b11, 16'h3c3c, 1'b0, 16'h0000, 8'd1, 1'b0};
    op_table[11] = '{1'b1, 1'b0, 1'b0, 19'h00103, 2'b11, 16'h0000, 1'b1, 16'h3c3c, 8'd0, 1'b0};
    op_table[12] = '{1'b1, 1'b0, 1'b1, 19'h52340, 2'b11, 16'h9876, 1'b0, 16'h0000, 8'd1, 1'b0};
    op_table[13] = '{1'b0, 1'b0, 1'b0, 19'h52340, 2'b11, 16'h0000, 1'b1, 16'h9876, 8'd8, 1'b0};
    op_table[14] = '{1'b0, 1'b0, 1'b0, 19'h52347, 2'b11, 16'h0000, 1'b0, 16'h401d, 8'd1, 1'b0};
    // Both ports at once, hits then misses
    op_table[15] = '{1'b0, 1'b0, 1'b0, 19'h00101, 2'b11, 16'h0000, 1'b1, 16'hc25b, 8'd0, 1'b1};
    op_table[16] = '{1'b1, 1'b0, 1'b0, 19'h52343, 2'b11, 16'h0000, 1'b1, 16'h4019, 8'd0, 1'b0};
    op_table[17] = '{1'b0, 1'b0, 1'b0, 19'h00200, 2'b11, 16'h0000, 1'b1, 16'hc15a, 8'd8, 1'b1};
    op_table[18] = '{1'b1, 1'b0, 1'b1, 19'h00410, 2'b11, 16'hbeef, 1'b1, 16'h0000, 8'd1, 1'b0};
    op_table[19] = '{1'b1, 1'b0, 1'b0, 19'h00410, 2'b11, 16'h0000, 1'b1, 16'hbeef, 8'd8, 1'b0};
    op_table[20] = '{1'b0, 1'b0, 1'b0, 19'h00203, 2'b11, 16'h0000, 1'b1, 16'hc159, 8'd0, 1'b0};
  endtask

  // Issues one op, or two on both ports, and waits for every ack
  task automatic run_ops(input int first, input int count);
    op_t op;
    cpu_bus_pkg::bus_req_t req;
    logic [15:0] got [2];
    logic [1:0] done;
    int unsigned start_count;
    int expected_mem;
    int k;
    @(posedge clk);
    start_count = mem_count;
    expected_mem = 0;
    done = (count == 1) ? 2'b10 : 2'b00;
    cache_enabled <= op_table[first].cache_en;
    for (k = 0; k < count; k++) begin
      op = op_table[first + k];
      expected_mem += int'(op.exp_mem);
      req = '{access: 1'b1, wr_en: op.wr_en, io: op.io, addr: op.addr, data: op.data,
              bytesel: op.bytesel};
      if (op.is_data) begin
        data_req <= req;
      end else begin
        instr_req <= req;
      end
    end
    while (done != 2'b11) begin
      @(posedge clk);
      for (k = 0; k < count; k++) begin
        op = op_table[first + k];
        if (!done[k] && op.is_data && data_rsp.ack) begin
          done[k] = 1'b1;
          got[k] = data_rsp.data;
          data_req <= '0;
        end else if (!done[k] && !op.is_data && instr_rsp.ack) begin
          done[k] = 1'b1;
          got[k] = instr_rsp.data;
          instr_req <= '0;
        end
      end
    end
    for (k = 0; k < count; k++) begin
      op = op_table[first + k];
      if (!op.wr_en) begin
        check_value(32'(got[k]), 32'(op.exp_data), $sformatf("op %0d read data", first + k));
      end
      if (op.io && op.wr_en) begin
        check_value(32'(io_last_addr), 32'(op.addr[3:0]),
                    $sformatf("op %0d I/O write register", first + k));
        check_value(32'(io_last_data), 32'(op.data),
                    $sformatf("op %0d I/O write data", first + k));
      end
    end
    check_value(mem_count - start_count, expected_mem,
                $sformatf("op %0d memory access count", first));
  endtask

  initial begin
    int idx;
    void'($urandom(32'ha07e_8db9));
    arst_n = 1'b0;
    cache_enabled = 1'b0;
    instr_req = '0;
    data_req = '0;
    load_table();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    idx = 0;
    while (idx < num_ops) begin
      if (op_table[idx].with_next) begin
        run_ops(idx, 2);
        idx += 2;
      end else begin
        run_ops(idx, 1);
        idx += 1;
      end
    end
    repeat (2) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

  // Budget of 40 cycles per op on top of reset
  initial begin
    repeat (num_ops * 40 + 4) @(posedge clk);
    $display("Watchdog expired: the run hung waiting for an ack");
    $display("Test failures found");
    $fatal(1, "Timeout");
  end

endmodule
